// File: mem_manager_pkg.sv
package mem_manager_pkg;

  // word and address width
  localparam int DATA_W = 32;

  // sixteen registers in memory at reg_base
  localparam int REG_NUM_W = 4;
  localparam logic [REG_NUM_W-1:0] IP_REG = 4'd15;

  // post-modify flag codes, 00 and 11 leave the register alone
  localparam int FLAG_W = 2;
  localparam logic [FLAG_W-1:0] FLAG_INC = 2'b01;
  localparam logic [FLAG_W-1:0] FLAG_DEC = 2'b10;

  // register number fields
  localparam int SRC1_NUM_LSB = 0;
  localparam int SRC0_NUM_LSB = 4;
  localparam int DST_NUM_LSB  = 8;
  localparam int COND_NUM_LSB = 12;

  // pointer bits
  localparam int SRC1_PTR_BIT = 16;
  localparam int SRC0_PTR_BIT = 17;
  localparam int DST_PTR_BIT  = 18;
  localparam int COND_PTR_BIT = 19;

  // flag pairs, same field order
  localparam int SRC1_FLG_LSB = 20;
  localparam int SRC0_FLG_LSB = 22;
  localparam int DST_FLG_LSB  = 24;
  localparam int COND_FLG_LSB = 26;

  // per-slot command from the sequencer
  typedef enum logic [1:0] {
    SLOT_IDLE,
    SLOT_READ,
    SLOT_PREP,
    SLOT_WRITE
  } slot_op_e;

  // instruction sequence
  typedef enum logic [3:0] {
    S_IDLE, S_FETCH, S_COND, S_SRC1, S_SRC0, S_ALU, S_DST_READ,
    S_PREP, S_WR_DST, S_WR_COND, S_WR_SRC1, S_WR_SRC0, S_DONE
  } seq_state_e;

endpackage

// File: op_sequencer.sv
`timescale 1ns/10ps

module op_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic                       alu_valid,
  input  logic                       fetch_done,
  input  logic                       slot_done,
  output logic                       fetch_go,
  output mem_manager_pkg::slot_op_e  cond_op,
  output mem_manager_pkg::slot_op_e  src1_op,
  output mem_manager_pkg::slot_op_e  src0_op,
  output mem_manager_pkg::slot_op_e  dst_op,
  output logic                       operands_valid,
  output logic                       instr_done
);
  import mem_manager_pkg::*;

  seq_state_e state;
  seq_state_e next_state;

  // ops are issued in the cycle the previous step finishes,
  // so a slot never sees a stale op after its own done
  always_comb begin
    next_state = state;
    fetch_go   = 1'b0;
    cond_op    = SLOT_IDLE;
    src1_op    = SLOT_IDLE;
    src0_op    = SLOT_IDLE;
    dst_op     = SLOT_IDLE;
    case (state)
      S_IDLE: begin
        if (start) begin
          fetch_go   = 1'b1;
          next_state = S_FETCH;
        end
      end
      S_FETCH: begin
        if (fetch_done) begin
          cond_op    = SLOT_READ;
          next_state = S_COND;
        end
      end
      S_COND: begin
        if (slot_done) begin
          src1_op    = SLOT_READ;
          next_state = S_SRC1;
        end
      end
      S_SRC1: begin
        if (slot_done) begin
          src0_op    = SLOT_READ;
          next_state = S_SRC0;
        end
      end
      S_SRC0: begin
        if (slot_done) next_state = S_ALU;
      end
      // dst slot samples alu_result together with its read op
      S_ALU: begin
        if (alu_valid) begin
          dst_op     = SLOT_READ;
          next_state = S_DST_READ;
        end
      end
      // all four slots compute post-modify values at once
      S_DST_READ: begin
        if (slot_done) begin
          cond_op    = SLOT_PREP;
          src1_op    = SLOT_PREP;
          src0_op    = SLOT_PREP;
          dst_op     = SLOT_PREP;
          next_state = S_PREP;
        end
      end
      // prep dones land here and are dropped, single cycle
      S_PREP: begin
        dst_op     = SLOT_WRITE;
        next_state = S_WR_DST;
      end
      S_WR_DST: begin
        if (slot_done) begin
          cond_op    = SLOT_WRITE;
          next_state = S_WR_COND;
        end
      end
      S_WR_COND: begin
        if (slot_done) begin
          src1_op    = SLOT_WRITE;
          next_state = S_WR_SRC1;
        end
      end
      S_WR_SRC1: begin
        if (slot_done) begin
          src0_op    = SLOT_WRITE;
          next_state = S_WR_SRC0;
        end
      end
      S_WR_SRC0: begin
        if (slot_done) next_state = S_DONE;
      end
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= S_IDLE;
      operands_valid <= 1'b0;
      instr_done     <= 1'b0;
    end else begin
      state          <= next_state;
      // last source finished
      operands_valid <= (state == S_SRC0) && slot_done;
      // high for the single S_DONE cycle
      instr_done     <= (state == S_WR_SRC0) && slot_done;
    end
  end

endmodule

// File: instr_fetch.sv
`timescale 1ns/10ps

module instr_fetch #(
  parameter int DW = mem_manager_pkg::DATA_W
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          fetch_go,
  input  logic [DW-1:0] reg_base,
  input  logic [DW-1:0] mem_rdata,
  input  logic          mem_done,
  output logic [DW-1:0] bus_addr,
  output logic [DW-1:0] bus_wdata,
  output logic          bus_read,
  output logic          bus_write,
  output logic [DW-1:0] cmd_word,
  output logic          fetch_done
);
  import mem_manager_pkg::*;

  typedef enum logic [1:0] {F_IDLE, F_RD_IP, F_RD_CMD, F_WR_IP} fetch_phase_e;

  fetch_phase_e  phase;
  logic [DW-1:0] ip;
  logic [DW-1:0] ip_addr;
  logic [DW-1:0] addr_sel;

  // ip lives in register 15
  assign ip_addr  = reg_base + DW'(IP_REG);
  // only the command read goes through ip itself
  assign addr_sel = (phase == F_RD_CMD) ? ip : ip_addr;

  // zeros while idle, the top ORs all requesters
  assign bus_addr  = (bus_read || bus_write) ? addr_sel : '0;
  assign bus_wdata = bus_write ? ip + DW'(1) : '0;

  // each phase raises its request one cycle after entry
  // and drops it on the edge after mem_done
  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= F_IDLE;
      bus_read   <= 1'b0;
      bus_write  <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      fetch_done <= 1'b0;
      case (phase)
        F_IDLE: begin
          if (fetch_go) phase <= F_RD_IP;
        end
        F_RD_IP: begin
          if (!bus_read) begin
            bus_read <= 1'b1;
          end else if (mem_done) begin
            bus_read <= 1'b0;
            ip       <= mem_rdata;
            phase    <= F_RD_CMD;
          end
        end
        F_RD_CMD: begin
          if (!bus_read) begin
            bus_read <= 1'b1;
          end else if (mem_done) begin
            bus_read <= 1'b0;
            cmd_word <= mem_rdata;
            phase    <= F_WR_IP;
          end
        end
        // post-increment of ip
        F_WR_IP: begin
          if (!bus_write) begin
            bus_write <= 1'b1;
          end else if (mem_done) begin
            bus_write  <= 1'b0;
            fetch_done <= 1'b1;
            phase      <= F_IDLE;
          end
        end
        default: phase <= F_IDLE;
      endcase
    end
  end

endmodule

// File: operand_slot.sv
`timescale 1ns/10ps

module operand_slot #(
  parameter int DW     = mem_manager_pkg::DATA_W,
  parameter bit IS_DST = 1'b0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  mem_manager_pkg::slot_op_e            op,
  input  logic [DW-1:0]                        reg_base,
  input  logic [mem_manager_pkg::REG_NUM_W-1:0] reg_num,
  input  logic                                 is_ptr,
  input  logic [mem_manager_pkg::FLAG_W-1:0]   flags,
  input  logic                                 is_alias,
  input  logic [DW-1:0]                        alias_reg,
  input  logic [DW-1:0]                        alu_result,
  input  logic [DW-1:0]                        mem_rdata,
  input  logic                                 mem_done,
  output logic [DW-1:0]                        bus_addr,
  output logic [DW-1:0]                        bus_wdata,
  output logic                                 bus_read,
  output logic                                 bus_write,
  output logic [DW-1:0]                        reg_val,
  output logic [DW-1:0]                        opnd_val,
  output logic                                 done
);
  import mem_manager_pkg::*;

  typedef enum logic [2:0] {P_IDLE, P_RD_REG, P_RD_PTR, P_WR_MAIN, P_WR_BACK} slot_state_e;

  slot_state_e   st;
  logic [DW-1:0] reg_addr;
  logic [DW-1:0] addr_sel;
  logic [DW-1:0] wb_val;
  logic          wb_en;

  assign reg_addr = reg_base + DW'(reg_num);

  // pointer deref and dst store through the pointer use reg_val
  always_comb begin
    case (st)
      P_RD_PTR:  addr_sel = reg_val;
      P_WR_MAIN: addr_sel = is_ptr ? reg_val : reg_addr;
      default:   addr_sel = reg_addr;
    endcase
  end

  assign bus_addr  = (bus_read || bus_write) ? addr_sel : '0;
  // dst store data sits in opnd_val
  assign bus_wdata = !bus_write ? '0 : (st == P_WR_MAIN) ? opnd_val : wb_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      st        <= P_IDLE;
      bus_read  <= 1'b0;
      bus_write <= 1'b0;
      wb_en     <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (st)
        P_IDLE: begin
          case (op)
            SLOT_READ: begin
              if (IS_DST) begin
                // alu_result is only valid with this op
                opnd_val <= alu_result;
                if (is_ptr) st <= P_RD_REG;
                else done <= 1'b1;
              end else if (is_alias) begin
                // register already read by an earlier field
                reg_val <= alias_reg;
                if (is_ptr) begin
                  st <= P_RD_PTR;
                end else begin
                  opnd_val <= alias_reg;
                  done     <= 1'b1;
                end
              end else begin
                st <= P_RD_REG;
              end
            end
            SLOT_PREP: begin
              case (flags)
                FLAG_INC: wb_val <= reg_val + DW'(1);
                FLAG_DEC: wb_val <= reg_val - DW'(1);
                default:  wb_val <= reg_val;
              endcase
              // aliases never write back, dst only modifies a pointer
              wb_en <= (flags == FLAG_INC || flags == FLAG_DEC) && !is_alias
                       && (!IS_DST || is_ptr);
              done  <= 1'b1;
            end
            SLOT_WRITE: begin
              if (IS_DST) st <= P_WR_MAIN;
              else if (wb_en) st <= P_WR_BACK;
              else done <= 1'b1;
            end
            default: st <= P_IDLE;
          endcase
        end
        P_RD_REG: begin
          if (!bus_read) begin
            bus_read <= 1'b1;
          end else if (mem_done) begin
            bus_read <= 1'b0;
            reg_val  <= mem_rdata;
            if (is_ptr && !IS_DST) begin
              st <= P_RD_PTR;
            end else begin
              if (!IS_DST) opnd_val <= mem_rdata;
              st   <= P_IDLE;
              done <= 1'b1;
            end
          end
        end
        P_RD_PTR: begin
          if (!bus_read) begin
            bus_read <= 1'b1;
          end else if (mem_done) begin
            bus_read <= 1'b0;
            opnd_val <= mem_rdata;
            st       <= P_IDLE;
            done     <= 1'b1;
          end
        end
        // dst store, register or pointed word
        P_WR_MAIN: begin
          if (!bus_write) begin
            bus_write <= 1'b1;
          end else if (mem_done) begin
            bus_write <= 1'b0;
            if (wb_en) begin
              st <= P_WR_BACK;
            end else begin
              st   <= P_IDLE;
              done <= 1'b1;
            end
          end
        end
        P_WR_BACK: begin
          if (!bus_write) begin
            bus_write <= 1'b1;
          end else if (mem_done) begin
            bus_write <= 1'b0;
            st        <= P_IDLE;
            done      <= 1'b1;
          end
        end
        default: st <= P_IDLE;
      endcase
    end
  end

endmodule

// File: mem_manager.sv
`timescale 1ns/10ps

module mem_manager #(
  parameter int DW = mem_manager_pkg::DATA_W
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  logic [DW-1:0] reg_base,
  input  logic [DW-1:0] alu_result,
  input  logic          alu_valid,
  input  logic [DW-1:0] mem_rdata,
  input  logic          mem_done,
  output logic [DW-1:0] mem_addr,
  output logic [DW-1:0] mem_wdata,
  output logic          mem_read,
  output logic          mem_write,
  output logic [DW-1:0] cmd_word,
  output logic [DW-1:0] cond_val,
  output logic [DW-1:0] src1_val,
  output logic [DW-1:0] src0_val,
  output logic          operands_valid,
  output logic          instr_done
);
  import mem_manager_pkg::*;

  slot_op_e cond_op, src1_op, src0_op, dst_op;
  logic fetch_go, fetch_done, slot_done;
  logic cond_done, src1_done, src0_done, dst_done;

  // per-requester bus outputs
  logic [DW-1:0] f_addr, c_addr, s1_addr, s0_addr, d_addr;
  logic [DW-1:0] f_wdata, c_wdata, s1_wdata, s0_wdata, d_wdata;
  logic f_rd, c_rd, s1_rd, s0_rd, d_rd;
  logic f_wr, c_wr, s1_wr, s0_wr, d_wr;

  // field decode
  logic [REG_NUM_W-1:0] cond_num, src1_num, src0_num, dst_num;
  logic [FLAG_W-1:0]    cond_flg, src1_flg, src0_flg, dst_flg;

  // alias forwarding
  logic          src1_alias, src0_alias, src0_on_cond;
  logic [DW-1:0] cond_reg, src1_reg, src0_alias_reg;

  assign cond_num = cmd_word[COND_NUM_LSB +: REG_NUM_W];
  assign src1_num = cmd_word[SRC1_NUM_LSB +: REG_NUM_W];
  assign src0_num = cmd_word[SRC0_NUM_LSB +: REG_NUM_W];
  assign dst_num  = cmd_word[DST_NUM_LSB +: REG_NUM_W];
  assign cond_flg = cmd_word[COND_FLG_LSB +: FLAG_W];
  assign src1_flg = cmd_word[SRC1_FLG_LSB +: FLAG_W];
  assign src0_flg = cmd_word[SRC0_FLG_LSB +: FLAG_W];
  assign dst_flg  = cmd_word[DST_FLG_LSB +: FLAG_W];

  // src1 checks cond, src0 checks cond first then src1
  assign src1_alias     = (src1_num == cond_num);
  assign src0_on_cond   = (src0_num == cond_num);
  assign src0_alias     = src0_on_cond || (src0_num == src1_num);
  assign src0_alias_reg = src0_on_cond ? cond_reg : src1_reg;

  // one requester at a time, idle ones drive zeros
  assign mem_addr  = f_addr | c_addr | s1_addr | s0_addr | d_addr;
  assign mem_wdata = f_wdata | c_wdata | s1_wdata | s0_wdata | d_wdata;
  assign mem_read  = f_rd | c_rd | s1_rd | s0_rd | d_rd;
  assign mem_write = f_wr | c_wr | s1_wr | s0_wr | d_wr;
  assign slot_done = cond_done | src1_done | src0_done | dst_done;

  op_sequencer u_seq (
    .clk(clk), .rst(rst), .start(start), .alu_valid(alu_valid),
    .fetch_done(fetch_done), .slot_done(slot_done), .fetch_go(fetch_go),
    .cond_op(cond_op), .src1_op(src1_op), .src0_op(src0_op), .dst_op(dst_op),
    .operands_valid(operands_valid), .instr_done(instr_done)
  );

  instr_fetch #(.DW(DW)) u_fetch (
    .clk(clk), .rst(rst), .fetch_go(fetch_go), .reg_base(reg_base),
    .mem_rdata(mem_rdata), .mem_done(mem_done),
    .bus_addr(f_addr), .bus_wdata(f_wdata), .bus_read(f_rd), .bus_write(f_wr),
    .cmd_word(cmd_word), .fetch_done(fetch_done)
  );

  // cond is first in line, never aliases
  operand_slot #(.DW(DW), .IS_DST(1'b0)) cond_slot (
    .clk(clk), .rst(rst), .op(cond_op), .reg_base(reg_base),
    .reg_num(cond_num), .is_ptr(cmd_word[COND_PTR_BIT]), .flags(cond_flg),
    .is_alias(1'b0), .alias_reg('0), .alu_result('0),
    .mem_rdata(mem_rdata), .mem_done(mem_done),
    .bus_addr(c_addr), .bus_wdata(c_wdata), .bus_read(c_rd), .bus_write(c_wr),
    .reg_val(cond_reg), .opnd_val(cond_val), .done(cond_done)
  );

  operand_slot #(.DW(DW), .IS_DST(1'b0)) src1_slot (
    .clk(clk), .rst(rst), .op(src1_op), .reg_base(reg_base),
    .reg_num(src1_num), .is_ptr(cmd_word[SRC1_PTR_BIT]), .flags(src1_flg),
    .is_alias(src1_alias), .alias_reg(cond_reg), .alu_result('0),
    .mem_rdata(mem_rdata), .mem_done(mem_done),
    .bus_addr(s1_addr), .bus_wdata(s1_wdata), .bus_read(s1_rd), .bus_write(s1_wr),
    .reg_val(src1_reg), .opnd_val(src1_val), .done(src1_done)
  );

  operand_slot #(.DW(DW), .IS_DST(1'b0)) src0_slot (
    .clk(clk), .rst(rst), .op(src0_op), .reg_base(reg_base),
    .reg_num(src0_num), .is_ptr(cmd_word[SRC0_PTR_BIT]), .flags(src0_flg),
    .is_alias(src0_alias), .alias_reg(src0_alias_reg), .alu_result('0),
    .mem_rdata(mem_rdata), .mem_done(mem_done),
    .bus_addr(s0_addr), .bus_wdata(s0_wdata), .bus_read(s0_rd), .bus_write(s0_wr),
    .reg_val(), .opnd_val(src0_val), .done(src0_done)
  );

  // dst always goes to the bus, takes the alu result
  operand_slot #(.DW(DW), .IS_DST(1'b1)) dst_slot (
    .clk(clk), .rst(rst), .op(dst_op), .reg_base(reg_base),
    .reg_num(dst_num), .is_ptr(cmd_word[DST_PTR_BIT]), .flags(dst_flg),
    .is_alias(1'b0), .alias_reg('0), .alu_result(alu_result),
    .mem_rdata(mem_rdata), .mem_done(mem_done),
    .bus_addr(d_addr), .bus_wdata(d_wdata), .bus_read(d_rd), .bus_write(d_wr),
    .reg_val(), .opnd_val(), .done(dst_done)
  );

endmodule

// File: mem_manager_assert.sv
`timescale 1ns/10ps

module mem_manager_assert #(
  parameter int DW = mem_manager_pkg::DATA_W
) (
  input logic                        clk,
  input logic                        rst,
  input logic [DW-1:0]               mem_addr,
  input logic [DW-1:0]               mem_wdata,
  input logic                        mem_read,
  input logic                        mem_write,
  input logic                        mem_done,
  input logic                        operands_valid,
  input logic                        instr_done,
  input mem_manager_pkg::seq_state_e seq_state
);
  import mem_manager_pkg::*;

  // failure tally
  int fail_count = 0;

  // one direction at a time
  rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else begin
      fail_count = fail_count + 1;
      $error("mem_read and mem_write high together");
    end

  // read held with a steady address until done
  rd_hold: assert property (@(posedge clk) disable iff (rst)
      (mem_read && !mem_done) |=> (mem_read && $stable(mem_addr)))
    else begin
      fail_count = fail_count + 1;
      $error("read request or address changed before mem_done");
    end

  // write keeps address and data too
  wr_hold: assert property (@(posedge clk) disable iff (rst)
      (mem_write && !mem_done) |=> (mem_write && $stable(mem_addr) && $stable(mem_wdata)))
    else begin
      fail_count = fail_count + 1;
      $error("write request, address or data changed before mem_done");
    end

  // request drops on the edge after done
  req_drop: assert property (@(posedge clk) disable iff (rst)
      mem_done |=> !(mem_read || mem_write))
    else begin
      fail_count = fail_count + 1;
      $error("request still high after mem_done");
    end

  ov_pulse: assert property (@(posedge clk) disable iff (rst)
      operands_valid |=> !operands_valid)
    else begin
      fail_count = fail_count + 1;
      $error("operands_valid longer than one cycle");
    end

  done_pulse: assert property (@(posedge clk) disable iff (rst) instr_done |=> !instr_done)
    else begin
      fail_count = fail_count + 1;
      $error("instr_done longer than one cycle");
    end

  // bus stays quiet while waiting on the alu
  alu_quiet: assert property (@(posedge clk) disable iff (rst)
      (seq_state == S_ALU) |-> !(mem_read || mem_write))
    else begin
      fail_count = fail_count + 1;
      $error("bus request during S_ALU");
    end

  // state right after reset
  reset_idle: assert property (@(posedge clk) $fell(rst) |->
      (!mem_read && !mem_write && !operands_valid && !instr_done && seq_state == S_IDLE))
    else begin
      fail_count = fail_count + 1;
      $error("unit not idle after reset");
    end

endmodule

// File: tb_mem_manager.sv
`timescale 1ns/10ps

module tb_mem_manager;

  localparam int DW = 32;
  // register file at 0x40..0x4f, ip in 0x4f
  localparam logic [DW-1:0] RB = 32'h40;
  localparam int N_INSTR = 8;
  // 8 instr x 15 accesses x 5 cycles is 600, the rest is margin
  localparam int CYCLE_LIMIT = 1500;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          start = 1'b0;
  logic [DW-1:0] reg_base = RB;
  logic [DW-1:0] alu_result = '0;
  logic          alu_valid = 1'b0;
  logic [DW-1:0] mem_rdata = '0;
  logic          mem_done = 1'b0;
  logic [DW-1:0] mem_addr, mem_wdata;
  logic          mem_read, mem_write;
  logic [DW-1:0] cmd_word, cond_val, src1_val, src0_val;
  logic          operands_valid, instr_done;

  // memory seen by the dut, its reference image and read counters
  logic [DW-1:0] mem [0:255];
  logic [DW-1:0] ref_mem [0:255];
  int            rd_cnt [0:255];
  int            ref_cnt [0:255];

  integer        seed = 17;
  logic          busy = 1'b0;
  int            wait_cnt = 0;
  logic          alu_wait = 1'b0;
  int            cycle_cnt = 0;
  logic [DW-1:0] exp_cmd, exp_cond, exp_src1, exp_src0;

  always #20 clk = ~clk;

  mem_manager #(.DW(DW)) uut (
    .clk(clk), .rst(rst), .start(start), .reg_base(reg_base),
    .alu_result(alu_result), .alu_valid(alu_valid),
    .mem_rdata(mem_rdata), .mem_done(mem_done), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write),
    .cmd_word(cmd_word), .cond_val(cond_val), .src1_val(src1_val),
    .src0_val(src0_val), .operands_valid(operands_valid), .instr_done(instr_done)
  );

  bind mem_manager mem_manager_assert #(.DW(DW)) mm_chk (
    .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write), .mem_done(mem_done),
    .operands_valid(operands_valid), .instr_done(instr_done),
    .seq_state(u_seq.state)
  );

  // one access at a time, done 1 to 4 cycles after the request is seen
  always @(posedge clk) begin
    mem_done <= 1'b0;
    if (rst) begin
      busy <= 1'b0;
    end else if ((mem_read || mem_write) && !mem_done) begin
      if (!busy) begin
        busy     <= 1'b1;
        wait_cnt <= $unsigned($random(seed)) % 4;
      end else if (wait_cnt == 0) begin
        busy     <= 1'b0;
        mem_done <= 1'b1;
        if (mem_write) begin
          mem[mem_addr[7:0]] <= mem_wdata;
        end else begin
          mem_rdata             <= mem[mem_addr[7:0]];
          rd_cnt[mem_addr[7:0]] <= rd_cnt[mem_addr[7:0]] + 1;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  // alu stub, sum two cycles after operands_valid
  always @(posedge clk) begin
    if (rst) begin
      alu_wait  <= 1'b0;
      alu_valid <= 1'b0;
    end else begin
      alu_wait  <= operands_valid;
      alu_valid <= alu_wait;
      if (alu_wait) alu_result <= src0_val + src1_val;
    end
  end

  // watchdog and bound assertion monitor
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (uut.mm_chk.fail_count != 0) begin
      $display("bus protocol assertion failed at cycle %0d", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1, "protocol error");
    end else if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, instructions did not finish", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check_word(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    assert (act === exp) else begin
      $display("FAILED %s expected %08h actual %08h", name, exp, act);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // reference accesses, counted like the bus
  function automatic logic [DW-1:0] read_word(input logic [DW-1:0] addr);
    ref_cnt[addr[7:0]] = ref_cnt[addr[7:0]] + 1;
    return ref_mem[addr[7:0]];
  endfunction

  function automatic void write_word(input logic [DW-1:0] addr, input logic [DW-1:0] data);
    ref_mem[addr[7:0]] = data;
  endfunction

  // 01 steps up, 10 steps down
  function automatic logic flag_active(input logic [1:0] flg);
    return (flg == 2'b01) || (flg == 2'b10);
  endfunction

  function automatic logic [DW-1:0] modify_reg(input logic [DW-1:0] val, input logic [1:0] flg);
    if (flg == 2'b01) return val + 1;
    if (flg == 2'b10) return val - 1;
    return val;
  endfunction

  // whole instruction on the reference image
  task automatic predict_instr();
    logic [DW-1:0] ip;
    logic [DW-1:0] c_reg, s1_reg, s0_reg, d_reg;
    logic [3:0]    cn, s1n, s0n, dn;
    logic [1:0]    cf, s1f, s0f, df;
    logic          cp, s1p, s0p, dp, s1_alias, s0_alias;
    ip      = read_word(RB + 15);
    exp_cmd = read_word(ip);
    write_word(RB + 15, ip + 1);
    {cf, df, s0f, s1f} = exp_cmd[27:20];
    {cp, dp, s0p, s1p} = exp_cmd[19:16];
    {cn, dn, s0n, s1n} = exp_cmd[15:0];
    // sources in order, a repeated number reuses the earlier register
    c_reg = read_word(RB + cn);
    if (cp) exp_cond = read_word(c_reg);
    else exp_cond = c_reg;
    s1_alias = (s1n == cn);
    if (s1_alias) s1_reg = c_reg;
    else s1_reg = read_word(RB + s1n);
    if (s1p) exp_src1 = read_word(s1_reg);
    else exp_src1 = s1_reg;
    s0_alias = (s0n == cn) || (s0n == s1n);
    if (s0n == cn) s0_reg = c_reg;
    else if (s0n == s1n) s0_reg = s1_reg;
    else s0_reg = read_word(RB + s0n);
    if (s0p) exp_src0 = read_word(s0_reg);
    else exp_src0 = s0_reg;
    // writes in dst, cond, src1, src0 order
    if (dp) begin
      d_reg = read_word(RB + dn);
      write_word(d_reg, exp_src0 + exp_src1);
      if (flag_active(df)) write_word(RB + dn, modify_reg(d_reg, df));
    end else begin
      write_word(RB + dn, exp_src0 + exp_src1);
    end
    if (flag_active(cf)) write_word(RB + cn, modify_reg(c_reg, cf));
    if (flag_active(s1f) && !s1_alias) write_word(RB + s1n, modify_reg(s1_reg, s1f));
    if (flag_active(s0f) && !s0_alias) write_word(RB + s0n, modify_reg(s0_reg, s0f));
  endtask

  task automatic check_image(input int n);
    for (int a = 0; a < 256; a++) begin
      check_word($sformatf("instr%0d mem[%02h]", n, a), ref_mem[a], mem[a]);
      check_word($sformatf("instr%0d reads[%02h]", n, a), ref_cnt[a], rd_cnt[a]);
    end
  endtask

  initial begin
    // fill pattern differs for every address
    for (int a = 0; a < 256; a++) begin
      mem[a]    = 32'h5a00_0000 ^ (a * 32'h0001_0203);
      rd_cnt[a] = 0;
    end
    // registers point into the data region at 0x80
    for (int r = 0; r < 15; r++) mem[RB + r] = 32'h80 + 8 * r;
    mem[RB + 15] = '0;
    // direct operands, no flags
    mem[0] = 32'h1000_1432;
    // pointer cond and src1 with inc and dec, dst flags 11 ignored
    mem[1] = 32'h2769_5876;
    // src1 and src0 repeat cond
    mem[2] = 32'h3460_9a99;
    // src0 repeats src1 through a pointer, dst pointer with dec
    mem[3] = 32'h4217_1cbb;
    // cond write-back overwrites the dst store
    mem[4] = 32'h5420_3332;
    // dst pointer inc, then src1 dec on the same register
    mem[5] = 32'h6d2e_ed0d;
    // cond reads ip after its own increment
    mem[6] = 32'h7192_f654;
    // every field through a pointer
    mem[7] = 32'h865f_7021;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = mem[a];
      ref_cnt[a] = 0;
    end

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int n = 0; n < N_INSTR; n++) begin
      predict_instr();
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      // operands stay put until instr_done
      do @(posedge clk); while (!operands_valid);
      check_word($sformatf("instr%0d cmd_word", n), exp_cmd, cmd_word);
      check_word($sformatf("instr%0d cond_val", n), exp_cond, cond_val);
      check_word($sformatf("instr%0d src1_val", n), exp_src1, src1_val);
      check_word($sformatf("instr%0d src0_val", n), exp_src0, src0_val);
      do @(posedge clk); while (!instr_done);
      check_image(n);
    end
    if (uut.mm_chk.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("bus protocol assertion failed");
      $display(">>> FAIL");
      $fatal(1, "protocol error");
    end
  end

endmodule

// File: mem_manager.f
mem_manager_pkg.sv
op_sequencer.sv
instr_fetch.sv
operand_slot.sv
mem_manager.sv
mem_manager_assert.sv
tb_mem_manager.sv

// File: Bender.yml
package:
  name: mem_manager

sources:
  - mem_manager_pkg.sv
  - op_sequencer.sv
  - instr_fetch.sv
  - operand_slot.sv
  - mem_manager.sv
  - target: simulation
    files:
      - mem_manager_assert.sv
      - tb_mem_manager.sv
